//--- Bender.yml
package:
  name: exu_ecl_wb

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/exu_wb_pkg.sv
      - verilog/exu_wb_pipe_ctl.sv
      - verilog/exu_wb_port_arb.sv
      - verilog/exu_wb_sr_ctl.sv
      - verilog/exu_ecl_wb.sv
  - target: test
    include_dirs:
      - verilog
    files:
      - tb/exu_ecl_wb_checker.sv
      - tb/exu_ecl_wb_tb.sv

//--- exu_ecl_wb.f
+incdir+verilog
verilog/exu_wb_pkg.sv
verilog/exu_wb_pipe_ctl.sv
verilog/exu_wb_port_arb.sv
verilog/exu_wb_sr_ctl.sv
verilog/exu_ecl_wb.sv
tb/exu_ecl_wb_checker.sv
tb/exu_ecl_wb_tb.sv

//--- tb/exu_ecl_wb_checker.sv
`timescale 1ns/10ps
`default_nettype none

`include "exu_wb_consts.svh"

module exu_ecl_wb_checker (
   input  logic                  clk, rst,
   input  logic                  wen_d, wsr_inst_d, kill_e, kill_m, flush_w, inst_vld_w,
   input  logic                  ld_vld_g, ld_miss_g2,
   input  logic                  md_valid, md_sel_div, md_div_setcc, md_mul_setcc,
   input  exu_wb_pkg::rd_t       rd_m, ld_rd_g, md_div_rd, md_mul_rd, irf_rd_m, irf_rd_g,
   input  exu_wb_pkg::tid_t      tid_m, ld_tid_g, md_div_tid, md_mul_tid, irf_tid_m, irf_tid_g,
   input  logic                  wsr_inst_e, bypass_m, bypass_w, irf_wen_w,
   input  logic                  sel_load_m, sel_load_g, md_ready, irf_wen_w2, setcc_g,
   input  exu_wb_pkg::thr_mask_t longop_done_g,
   input  exu_wb_pkg::sraddr_t   sraddr_d,
   input  exu_wb_pkg::win_t      cwp_d, cansave_d, canrestore_d, otherwin_d, cleanwin_d,
   input  exu_wb_pkg::wstate_t   wstate_d,
   input  exu_wb_pkg::ccr_t      cc_d, eclpr_e,
   input  logic                  cwp_wen_e, ccr_wen_w, cansave_wen_w, canrestore_wen_w,
   input  logic                  otherwin_wen_w, wstate_wen_w, cleanwin_wen_w,
   output int                    value_errors,
   output int                    other_errors,
   output int                    check_count
);

   import exu_wb_pkg::*;

   // model state with one flop per stage of the unit
   logic    started;
   logic    prev_rst;
   logic    m_wb_e, m_wb_m, m_wb_w;
   logic    m_wrsr_e, m_wrsr_m, m_wrsr_w;
   logic    m_ld_g2, m_load_wen, m_wen_w2;
   rd_t     m_ld_rd;
   tid_t    m_ld_tid;
   sraddr_t m_sraddr_e, m_sraddr_m, m_sraddr_w;
   ccr_t    m_eclpr;

   // expected values of the current cycle
   logic      busy;
   logic      exp_sel_m;
   logic      exp_sel_g;
   logic      fire;
   rd_t       md_rd_x;
   tid_t      md_tid_x;
   logic      md_setcc_x;
   thr_mask_t exp_done;

   // mul/div request seen in the previous cycle
   logic        prev_stall;
   logic [16:0] prev_md;

   initial begin
      value_errors = 0;
      other_errors = 0;
      check_count  = 0;
      started      = 1'b0;
      prev_rst     = 1'b0;
      prev_stall   = 1'b0;
   end

   // rdpr result by the low four address bits
   function automatic ccr_t read_result(input sraddr_t addr, input win_t cwp,
                                        input win_t cansave, input win_t canrestore,
                                        input win_t otherwin, input win_t cleanwin,
                                        input wstate_t wstate, input ccr_t cc);
      case (addr[3:0])
         4'h8, 4'hc: return ccr_t'(cleanwin);
         4'h9:       return ccr_t'(cwp);
         4'ha:       return ccr_t'(cansave);
         4'hb, 4'hf: return ccr_t'(canrestore);
         4'hd:       return ccr_t'(otherwin);
         4'he:       return ccr_t'(wstate);
         default:    return cc;
      endcase
   endfunction

   task automatic check_value(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
      check_count++;
      if (actual !== expected) begin
         value_errors++;
         $display("** Error %s: expected %0h, actual %0h at %0t", name, expected, actual, $time);
      end
   endtask

   //////////////////////////////////////////////////
   // expected outputs from the model state
   //////////////////////////////////////////////////
   task automatic form_expected();
      busy       = m_wb_m || m_wrsr_m;
      exp_sel_m  = m_ld_g2 && !busy;
      exp_sel_g  = m_ld_g2 && busy;
      fire       = md_valid && !exp_sel_g;
      md_rd_x    = md_sel_div ? md_div_rd : md_mul_rd;
      md_tid_x   = md_sel_div ? md_div_tid : md_mul_tid;
      md_setcc_x = md_sel_div ? md_div_setcc : md_mul_setcc;
      exp_done   = '0;
      if (fire) begin
         exp_done[md_tid_x] = 1'b1;
      end
   endtask

   task automatic compare_outputs();
      check_value("irf_wen_w", (m_wb_w && !flush_w && inst_vld_w) || m_load_wen, irf_wen_w);
      check_value("bypass_m", m_wb_m, bypass_m);
      check_value("bypass_w", m_wb_w || m_load_wen, bypass_w);
      check_value("wsr_inst_e", m_wrsr_e, wsr_inst_e);
      check_value("sel_load_m", exp_sel_m, sel_load_m);
      check_value("sel_load_g", exp_sel_g, sel_load_g);
      check_value("irf_rd_m", exp_sel_m ? m_ld_rd : rd_m, irf_rd_m);
      check_value("irf_tid_m", exp_sel_m ? m_ld_tid : tid_m, irf_tid_m);
      check_value("md_ready", !exp_sel_g, md_ready);
      if (exp_sel_g || fire) begin
         check_value("irf_rd_g", exp_sel_g ? m_ld_rd : md_rd_x, irf_rd_g);
         check_value("irf_tid_g", exp_sel_g ? m_ld_tid : md_tid_x, irf_tid_g);
      end
      check_value("setcc_g", fire && md_setcc_x, setcc_g);
      check_value("longop_done_g", exp_done, longop_done_g);
      check_value("irf_wen_w2", m_wen_w2, irf_wen_w2);
      check_value("cwp_wen_e", m_wrsr_e && (m_sraddr_e == `SR_CWP), cwp_wen_e);
      // ccr, cansave, canrestore, cleanwin, otherwin, wstate
      check_value("sr_wen_w",
                  {m_wrsr_w && (m_sraddr_w == `SR_CCR),
                   m_wrsr_w && (m_sraddr_w == `SR_CANSAVE),
                   m_wrsr_w && (m_sraddr_w == `SR_CANRESTORE),
                   m_wrsr_w && (m_sraddr_w == `SR_CLEANWIN),
                   m_wrsr_w && (m_sraddr_w == `SR_OTHERWIN),
                   m_wrsr_w && (m_sraddr_w == `SR_WSTATE)},
                  {ccr_wen_w, cansave_wen_w, canrestore_wen_w, cleanwin_wen_w,
                   otherwin_wen_w, wstate_wen_w});
      check_value("eclpr_e", m_eclpr, eclpr_e);
      // all controls idle and md_ready high right after a reset edge
      if (prev_rst) begin
         check_value("reset_idle", 20'h1,
                     {irf_wen_w, irf_wen_w2, bypass_m, bypass_w, wsr_inst_e, cwp_wen_e,
                      ccr_wen_w, cansave_wen_w, canrestore_wen_w, cleanwin_wen_w,
                      otherwin_wen_w, wstate_wen_w, setcc_g, longop_done_g,
                      sel_load_m, sel_load_g, md_ready});
      end
      if (prev_stall && (md_valid !== 1'b1 ||
          {md_sel_div, md_div_rd, md_mul_rd, md_div_tid, md_mul_tid,
           md_div_setcc, md_mul_setcc} !== prev_md)) begin
         other_errors++;
         $display("mul/div request was dropped or changed while waiting for md_ready at %0t",
                  $time);
      end
   endtask

   //////////////////////////////////////////////////
   // model update at the rising edge
   //////////////////////////////////////////////////
   task automatic update_model();
      if (rst) begin
         m_wb_e     = 1'b0;
         m_wb_m     = 1'b0;
         m_wb_w     = 1'b0;
         m_wrsr_e   = 1'b0;
         m_wrsr_m   = 1'b0;
         m_wrsr_w   = 1'b0;
         m_ld_g2    = 1'b0;
         m_load_wen = 1'b0;
         m_wen_w2   = 1'b0;
         m_eclpr    = '0;
      end else begin
         // later stages first so each one takes the old value
         m_wb_w     = m_wb_m && !kill_m;
         m_wb_m     = m_wb_e && !kill_e && !m_wrsr_e;
         m_wb_e     = wen_d;
         m_wrsr_w   = m_wrsr_m;
         m_wrsr_m   = m_wrsr_e;
         m_wrsr_e   = wsr_inst_d;
         m_load_wen = exp_sel_m && !ld_miss_g2;
         m_wen_w2   = (exp_sel_g && !ld_miss_g2) || fire;
         m_ld_g2    = ld_vld_g;
         m_eclpr    = read_result(sraddr_d, cwp_d, cansave_d, canrestore_d, otherwin_d,
                                  cleanwin_d, wstate_d, cc_d);
      end
      m_ld_rd    = ld_rd_g;
      m_ld_tid   = ld_tid_g;
      m_sraddr_w = m_sraddr_m;
      m_sraddr_m = m_sraddr_e;
      m_sraddr_e = sraddr_d;
      prev_rst   = rst;
      prev_stall = md_valid && exp_sel_g;
      prev_md    = {md_sel_div, md_div_rd, md_mul_rd, md_div_tid, md_mul_tid,
                    md_div_setcc, md_mul_setcc};
   endtask

   // values are read before the flops of this edge update
   always @(posedge clk) begin
      form_expected();
      if (started) begin
         compare_outputs();
      end
      update_model();
      started = 1'b1;
   end

endmodule

`default_nettype wire

//--- tb/exu_ecl_wb_tb.sv
`timescale 1ns/10ps
`default_nettype none

`include "exu_wb_consts.svh"

module exu_ecl_wb_tb;

   import exu_wb_pkg::*;

   localparam int NUM_CYCLES  = 4000;
   localparam int DRAIN_LIMIT = 40;

   logic      clk;
   logic      rst;
   logic      wen_d, wsr_inst_d, kill_e, kill_m, flush_w, inst_vld_w;
   logic      ld_vld_g, ld_miss_g2;
   logic      md_valid, md_sel_div, md_div_setcc, md_mul_setcc;
   rd_t       rd_m, ld_rd_g, md_div_rd, md_mul_rd, irf_rd_m, irf_rd_g;
   tid_t      tid_m, ld_tid_g, md_div_tid, md_mul_tid, irf_tid_m, irf_tid_g;
   logic      wsr_inst_e, bypass_m, bypass_w, irf_wen_w;
   logic      sel_load_m, sel_load_g, md_ready, irf_wen_w2, setcc_g;
   thr_mask_t longop_done_g;
   sraddr_t   sraddr_d;
   win_t      cwp_d, cansave_d, canrestore_d, otherwin_d, cleanwin_d;
   wstate_t   wstate_d;
   ccr_t      cc_d, eclpr_e;
   logic      cwp_wen_e, ccr_wen_w, cansave_wen_w, canrestore_wen_w;
   logic      otherwin_wen_w, wstate_wen_w, cleanwin_wen_w;

   int   value_errors;
   int   other_errors;
   int   check_count;
   logic stalled;
   logic drained;
   int   idle_run;

   exu_ecl_wb dut (.*);

   exu_ecl_wb_checker u_checker (.*);

   initial clk = 1'b0;
   always #20 clk = ~clk;

   // mostly real state register addresses, sometimes any address
   function automatic sraddr_t pick_sraddr();
      case ($urandom % 10)
         0:       return `SR_CCR;
         1:       return `SR_CWP;
         2:       return `SR_CANSAVE;
         3:       return `SR_CANRESTORE;
         4:       return `SR_CLEANWIN;
         5:       return `SR_OTHERWIN;
         6:       return `SR_WSTATE;
         default: return sraddr_t'($urandom);
      endcase
   endfunction

   // random or idle inputs, a stalled mul/div request is left as it is
   task automatic drive_inputs(input logic random_on, input logic hold_md);
      wen_d        = random_on && ($urandom % 4 != 0);
      wsr_inst_d   = random_on && ($urandom % 8 == 0);
      kill_e       = random_on && ($urandom % 8 == 0);
      kill_m       = random_on && ($urandom % 8 == 0);
      flush_w      = random_on && ($urandom % 8 == 0);
      inst_vld_w   = random_on && ($urandom % 8 != 0);
      rd_m         = random_on ? rd_t'($urandom) : '0;
      tid_m        = random_on ? tid_t'($urandom) : '0;
      ld_vld_g     = random_on && ($urandom % 2 != 0);
      ld_rd_g      = random_on ? rd_t'($urandom) : '0;
      ld_tid_g     = random_on ? tid_t'($urandom) : '0;
      ld_miss_g2   = random_on && ($urandom % 4 == 0);
      if (!hold_md) begin
         md_valid     = random_on && ($urandom % 2 != 0);
         md_sel_div   = random_on && ($urandom % 2 != 0);
         md_div_rd    = random_on ? rd_t'($urandom) : '0;
         md_mul_rd    = random_on ? rd_t'($urandom) : '0;
         md_div_tid   = random_on ? tid_t'($urandom) : '0;
         md_mul_tid   = random_on ? tid_t'($urandom) : '0;
         md_div_setcc = random_on && ($urandom % 2 != 0);
         md_mul_setcc = random_on && ($urandom % 2 != 0);
      end
      sraddr_d     = random_on ? pick_sraddr() : '0;
      cwp_d        = random_on ? win_t'($urandom) : '0;
      cansave_d    = random_on ? win_t'($urandom) : '0;
      canrestore_d = random_on ? win_t'($urandom) : '0;
      otherwin_d   = random_on ? win_t'($urandom) : '0;
      cleanwin_d   = random_on ? win_t'($urandom) : '0;
      wstate_d     = random_on ? wstate_t'($urandom) : '0;
      cc_d         = random_on ? ccr_t'($urandom) : '0;
   endtask

   function automatic logic unit_busy();
      return wen_d || wsr_inst_d || ld_vld_g || md_valid || wsr_inst_e || bypass_m
             || bypass_w || irf_wen_w || irf_wen_w2 || sel_load_m || sel_load_g;
   endfunction

   //////////////////////////////////////////////////
   // stimulus
   //////////////////////////////////////////////////
   initial begin
      void'($urandom(32'h1299a12e));
      rst      = 1'b1;
      stalled  = 1'b0;
      drained  = 1'b0;
      idle_run = 0;
      drive_inputs(1'b0, 1'b0);
      // five rising edges in reset, then one idle cycle
      repeat (5) @(negedge clk);
      rst = 1'b0;
      for (int cycle = 0; cycle < NUM_CYCLES; cycle++) begin
         @(posedge clk);
         stalled = md_valid && !md_ready;
         @(negedge clk);
         drive_inputs(1'b1, stalled);
      end
      // drain until inputs and outputs stay quiet for a few cycles
      for (int waited = 0; waited < DRAIN_LIMIT && !drained; waited++) begin
         @(posedge clk);
         stalled = md_valid && !md_ready;
         if (unit_busy()) begin
            idle_run = 0;
         end else begin
            idle_run++;
         end
         drained = (idle_run >= 4);
         @(negedge clk);
         drive_inputs(1'b0, stalled);
      end
      if (!drained) begin
         $display("unit did not go idle within %0d cycles after the last stimulus",
                  DRAIN_LIMIT);
      end
      $display("errors: %0d wrong values, %0d other failures, %0d checks",
               value_errors, other_errors, check_count);
      if (drained && value_errors == 0 && other_errors == 0 && check_count > 0) begin
         $display("TB PASSED");
      end else begin
         $display("TB FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire

//--- verilog/exu_ecl_wb.sv
`timescale 1ns/10ps
`default_nettype none

module exu_ecl_wb (
   input  logic                  clk,
   input  logic                  rst,
   // pipeline
   input  logic                  wen_d,
   input  logic                  wsr_inst_d,
   input  logic                  kill_e,
   input  logic                  kill_m,
   input  logic                  flush_w,
   input  logic                  inst_vld_w,
   input  exu_wb_pkg::rd_t       rd_m,
   input  exu_wb_pkg::tid_t      tid_m,
   output logic                  wsr_inst_e,
   output logic                  bypass_m,
   output logic                  bypass_w,
   output logic                  irf_wen_w,
   // load return
   input  logic                  ld_vld_g,
   input  exu_wb_pkg::rd_t       ld_rd_g,
   input  exu_wb_pkg::tid_t      ld_tid_g,
   input  logic                  ld_miss_g2,
   output logic                  sel_load_m,
   output logic                  sel_load_g,
   output exu_wb_pkg::rd_t       irf_rd_m,
   output exu_wb_pkg::tid_t      irf_tid_m,
   // mul/div result
   input  logic                  md_valid,
   input  logic                  md_sel_div,
   input  exu_wb_pkg::rd_t       md_div_rd,
   input  exu_wb_pkg::rd_t       md_mul_rd,
   input  exu_wb_pkg::tid_t      md_div_tid,
   input  exu_wb_pkg::tid_t      md_mul_tid,
   input  logic                  md_div_setcc,
   input  logic                  md_mul_setcc,
   output logic                  md_ready,
   output exu_wb_pkg::rd_t       irf_rd_g,
   output exu_wb_pkg::tid_t      irf_tid_g,
   output logic                  irf_wen_w2,
   output logic                  setcc_g,
   output exu_wb_pkg::thr_mask_t longop_done_g,
   // state registers
   input  exu_wb_pkg::sraddr_t   sraddr_d,
   input  exu_wb_pkg::win_t      cwp_d,
   input  exu_wb_pkg::win_t      cansave_d,
   input  exu_wb_pkg::win_t      canrestore_d,
   input  exu_wb_pkg::win_t      otherwin_d,
   input  exu_wb_pkg::win_t      cleanwin_d,
   input  exu_wb_pkg::wstate_t   wstate_d,
   input  exu_wb_pkg::ccr_t      cc_d,
   output logic                  cwp_wen_e,
   output logic                  ccr_wen_w,
   output logic                  cansave_wen_w,
   output logic                  canrestore_wen_w,
   output logic                  otherwin_wen_w,
   output logic                  wstate_wen_w,
   output logic                  cleanwin_wen_w,
   output exu_wb_pkg::ccr_t      eclpr_e
);

   logic port_busy_m;
   logic load_wen_w;
   logic wrsr_w;

   // the E stage wrsr flag leaves the unit as wsr_inst_e
   exu_wb_pipe_ctl u_pipe_ctl (
      .*,
      .wrsr_e (wsr_inst_e)
   );

   exu_wb_port_arb u_port_arb (
      .*
   );

   exu_wb_sr_ctl u_sr_ctl (
      .*,
      .wrsr_e (wsr_inst_e)
   );

endmodule

`default_nettype wire

//--- verilog/exu_wb_consts.svh
`ifndef EXU_WB_CONSTS_SVH
`define EXU_WB_CONSTS_SVH

// thread and register widths
`define EXU_TID_W      2
`define EXU_NTHR       4
`define EXU_RD_W       5
`define EXU_SRADDR_W   7
`define EXU_WIN_W      3
`define EXU_WSTATE_W   6
`define EXU_CCR_W      8

// state register addresses, shared by wrsr and rdpr
`define SR_CCR         7'h02
`define SR_CWP         7'h09
`define SR_CANSAVE     7'h0a
`define SR_CANRESTORE  7'h0b
`define SR_CLEANWIN    7'h0c
`define SR_OTHERWIN    7'h0d
`define SR_WSTATE      7'h0e
`endif

//--- verilog/exu_wb_pipe_ctl.sv
`timescale 1ns/10ps
`default_nettype none

module exu_wb_pipe_ctl (
   input  logic clk,
   input  logic rst,
   input  logic wen_d,
   input  logic wsr_inst_d,
   input  logic kill_e,
   input  logic kill_m,
   input  logic flush_w,
   input  logic inst_vld_w,
   input  logic load_wen_w,
   output logic port_busy_m,
   output logic wrsr_e,
   output logic wrsr_w,
   output logic bypass_m,
   output logic bypass_w,
   output logic irf_wen_w
);

   logic wb_e;
   logic wb_m;
   logic wb_w;
   logic wrsr_m;
   logic valid_e;
   logic valid_m;

   //////////////////////////////////////////////////
   // pipe write enable, D to W
   //////////////////////////////////////////////////
   // a wrsr never writes the register file
   assign valid_e = wb_e & ~kill_e & ~wrsr_e;
   assign valid_m = wb_m & ~kill_m;

   always_ff @(posedge clk) begin
      if (rst) begin
         wb_e <= 1'b0;
         wb_m <= 1'b0;
         wb_w <= 1'b0;
      end else begin
         wb_e <= wen_d;
         wb_m <= valid_e;
         wb_w <= valid_m;
      end
   end

   // wrsr follows the same stages
   always_ff @(posedge clk) begin
      if (rst) begin
         wrsr_e <= 1'b0;
         wrsr_m <= 1'b0;
         wrsr_w <= 1'b0;
      end else begin
         wrsr_e <= wsr_inst_d;
         wrsr_m <= wrsr_e;
         wrsr_w <= wrsr_m;
      end
   end

   //////////////////////////////////////////////////
   // W1 port
   //////////////////////////////////////////////////
   // pipe or wrsr in M keeps loads off W1
   assign port_busy_m = wb_m | wrsr_m;

   // bypass does not wait for kill or flush
   assign bypass_m = wb_m;
   assign bypass_w = wb_w | load_wen_w;

   // the load term was already qualified by its miss in G2
   assign irf_wen_w = (wb_w & ~flush_w & inst_vld_w) | load_wen_w;

   // a W write can only come out of an M write
   a_wb_w_from_m: assert property (@(posedge clk) disable iff (rst)
      $rose(wb_w) |-> $past(wb_m))
      else $error("wb_w rose without wb_m in the previous cycle");

endmodule

`default_nettype wire

//--- verilog/exu_wb_pkg.sv
`default_nettype none

`include "exu_wb_consts.svh"

package exu_wb_pkg;

   // thread id and destination register of a write
   typedef logic [`EXU_TID_W-1:0]    tid_t;
   typedef logic [`EXU_RD_W-1:0]     rd_t;

   // one bit per thread
   typedef logic [`EXU_NTHR-1:0]     thr_mask_t;

   // state register address and window state fields
   typedef logic [`EXU_SRADDR_W-1:0] sraddr_t;
   typedef logic [`EXU_WIN_W-1:0]    win_t;
   typedef logic [`EXU_WSTATE_W-1:0] wstate_t;

   // condition codes, also the width of the rdpr result
   typedef logic [`EXU_CCR_W-1:0]    ccr_t;

endpackage

`default_nettype wire

//--- verilog/exu_wb_port_arb.sv
`timescale 1ns/10ps
`default_nettype none

`include "exu_wb_consts.svh"

module exu_wb_port_arb (
   input  logic                     clk,
   input  logic                     rst,
   input  logic                     ld_vld_g,
   input  exu_wb_pkg::rd_t          ld_rd_g,
   input  exu_wb_pkg::tid_t         ld_tid_g,
   input  logic                     ld_miss_g2,
   input  logic                     port_busy_m,
   input  exu_wb_pkg::rd_t          rd_m,
   input  exu_wb_pkg::tid_t         tid_m,
   input  logic                     md_valid,
   input  logic                     md_sel_div,
   input  exu_wb_pkg::rd_t          md_div_rd,
   input  exu_wb_pkg::rd_t          md_mul_rd,
   input  exu_wb_pkg::tid_t         md_div_tid,
   input  exu_wb_pkg::tid_t         md_mul_tid,
   input  logic                     md_div_setcc,
   input  logic                     md_mul_setcc,
   output logic                     md_ready,
   output logic                     sel_load_m,
   output logic                     sel_load_g,
   output exu_wb_pkg::rd_t          irf_rd_m,
   output exu_wb_pkg::rd_t          irf_rd_g,
   output exu_wb_pkg::tid_t         irf_tid_m,
   output exu_wb_pkg::tid_t         irf_tid_g,
   output logic                     load_wen_w,
   output logic                     irf_wen_w2,
   output logic                     setcc_g,
   output exu_wb_pkg::thr_mask_t    longop_done_g
);

   import exu_wb_pkg::*;

   logic ld_g2;
   rd_t  ld_rd_g2;
   tid_t ld_tid_g2;
   logic md_fire;
   rd_t  md_rd;
   tid_t md_tid;
   logic md_setcc;

   //////////////////////////////////////////////////
   // load held one cycle into G2
   //////////////////////////////////////////////////
   always_ff @(posedge clk) begin
      if (rst) begin
         ld_g2 <= 1'b0;
      end else begin
         ld_g2 <= ld_vld_g;
      end
   end

   always_ff @(posedge clk) begin
      ld_rd_g2  <= ld_rd_g;
      ld_tid_g2 <= ld_tid_g;
   end

   // free W1 takes the load, otherwise it goes to W2
   assign sel_load_m = ld_g2 & ~port_busy_m;
   assign sel_load_g = ld_g2 & port_busy_m;

   assign irf_rd_m  = sel_load_m ? ld_rd_g2 : rd_m;
   assign irf_tid_m = sel_load_m ? ld_tid_g2 : tid_m;

   //////////////////////////////////////////////////
   // W2 port, load first then mul/div
   //////////////////////////////////////////////////
   assign md_ready = ~sel_load_g;
   assign md_fire  = md_valid & md_ready;

   assign md_rd    = md_sel_div ? md_div_rd : md_mul_rd;
   assign md_tid   = md_sel_div ? md_div_tid : md_mul_tid;
   assign md_setcc = md_sel_div ? md_div_setcc : md_mul_setcc;

   assign irf_rd_g  = sel_load_g ? ld_rd_g2 : md_rd;
   assign irf_tid_g = sel_load_g ? ld_tid_g2 : md_tid;
   assign setcc_g   = md_fire & md_setcc;

   // completing thread of the mul/div result
   always_comb begin
      longop_done_g = '0;
      for (int t = 0; t < `EXU_NTHR; t++) begin
         longop_done_g[t] = md_fire & (md_tid == tid_t'(t));
      end
   end

   // a missed load still owns its port but writes nothing
   always_ff @(posedge clk) begin
      if (rst) begin
         load_wen_w <= 1'b0;
         irf_wen_w2 <= 1'b0;
      end else begin
         load_wen_w <= sel_load_m & ~ld_miss_g2;
         irf_wen_w2 <= (sel_load_g & ~ld_miss_g2) | md_fire;
      end
   end

   a_one_load_port: assert property (@(posedge clk) disable iff (rst)
      !(sel_load_m && sel_load_g))
      else $error("load selected on W1 and W2 in the same cycle");

   // source must hold a stalled mul/div request
   a_md_hold: assert property (@(posedge clk) disable iff (rst)
      (md_valid && !md_ready) |=> (md_valid && $stable(md_sel_div) && $stable(md_rd)
                                   && $stable(md_tid) && $stable(md_setcc)))
      else $error("mul/div request changed while stalled");

endmodule

`default_nettype wire

//--- verilog/exu_wb_sr_ctl.sv
`timescale 1ns/10ps
`default_nettype none

`include "exu_wb_consts.svh"

module exu_wb_sr_ctl (
   input  logic                  clk,
   input  logic                  rst,
   input  exu_wb_pkg::sraddr_t   sraddr_d,
   input  logic                  wrsr_e,
   input  logic                  wrsr_w,
   input  exu_wb_pkg::win_t      cwp_d,
   input  exu_wb_pkg::win_t      cansave_d,
   input  exu_wb_pkg::win_t      canrestore_d,
   input  exu_wb_pkg::win_t      otherwin_d,
   input  exu_wb_pkg::win_t      cleanwin_d,
   input  exu_wb_pkg::wstate_t   wstate_d,
   input  exu_wb_pkg::ccr_t      cc_d,
   output logic                  cwp_wen_e,
   output logic                  ccr_wen_w,
   output logic                  cansave_wen_w,
   output logic                  canrestore_wen_w,
   output logic                  otherwin_wen_w,
   output logic                  wstate_wen_w,
   output logic                  cleanwin_wen_w,
   output exu_wb_pkg::ccr_t      eclpr_e
);

   import exu_wb_pkg::*;

   sraddr_t sraddr_e;
   sraddr_t sraddr_m;
   sraddr_t sraddr_w;
   ccr_t    rdpr_d;

   // address rides along with the wrsr
   always_ff @(posedge clk) begin
      sraddr_e <= sraddr_d;
      sraddr_m <= sraddr_e;
      sraddr_w <= sraddr_m;
   end

   //////////////////////////////////////////////////
   // wrsr decode
   //////////////////////////////////////////////////
   // cwp is written early, in E
   assign cwp_wen_e        = wrsr_e & (sraddr_e == `SR_CWP);
   assign ccr_wen_w        = wrsr_w & (sraddr_w == `SR_CCR);
   assign cansave_wen_w    = wrsr_w & (sraddr_w == `SR_CANSAVE);
   assign canrestore_wen_w = wrsr_w & (sraddr_w == `SR_CANRESTORE);
   assign cleanwin_wen_w   = wrsr_w & (sraddr_w == `SR_CLEANWIN);
   assign otherwin_wen_w   = wrsr_w & (sraddr_w == `SR_OTHERWIN);
   assign wstate_wen_w     = wrsr_w & (sraddr_w == `SR_WSTATE);

   //////////////////////////////////////////////////
   // rdpr mux on the low address bits
   //////////////////////////////////////////////////
   // window registers share bits 1:0 once cwp and wstate are out of the way
   always_comb begin
      if (!sraddr_d[3]) begin
         rdpr_d = cc_d;
      end else if (sraddr_d[3:0] == 4'h9) begin
         rdpr_d = ccr_t'(cwp_d);
      end else if (sraddr_d[3:0] == 4'he) begin
         rdpr_d = ccr_t'(wstate_d);
      end else begin
         case (sraddr_d[1:0])
            2'b00:   rdpr_d = ccr_t'(cleanwin_d);
            2'b01:   rdpr_d = ccr_t'(otherwin_d);
            2'b10:   rdpr_d = ccr_t'(cansave_d);
            default: rdpr_d = ccr_t'(canrestore_d);
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         eclpr_e <= '0;
      end else begin
         eclpr_e <= rdpr_d;
      end
   end

   a_one_sr_wen: assert property (@(posedge clk) disable iff (rst)
      $onehot0({ccr_wen_w, cansave_wen_w, canrestore_wen_w, cleanwin_wen_w,
                otherwin_wen_w, wstate_wen_w}))
      else $error("more than one state register write enable in W");

endmodule

`default_nettype wire
